// ==== dv/tb_mips_ref.svh ====
// one expected register writeback
typedef struct packed {
    mips_pkg::word_t      pc;
    mips_pkg::creg_addr_t num;
    mips_pkg::word_t      data;
} wb_rec_t;

// one expected data store
typedef struct packed {
    mips_pkg::word_t addr;
    mips_pkg::word_t data;
} store_rec_t;

wb_rec_t    exp_wb[$];
store_rec_t exp_st[$];

// architectural run of prog, no delay slot, until pc leaves the program
task automatic run_reference();
    mips_pkg::word_t      gpr [0:31];
    mips_pkg::word_t      mem_model [0:DATA_LEN-1];
    mips_pkg::instr_t     ins;
    mips_pkg::word_t      pc;
    mips_pkg::word_t      nxt;
    mips_pkg::word_t      a;
    mips_pkg::word_t      b;
    mips_pkg::word_t      sext;
    mips_pkg::word_t      ea;
    mips_pkg::word_t      res;
    mips_pkg::creg_addr_t dst;
    logic                 wr_en;
    int                   idx;
    for (int i = 0; i < 32; i++) begin
        gpr[i] = '0;
    end
    for (int i = 0; i < DATA_LEN; i++) begin
        mem_model[i] = fill_word(i * 4);
    end
    pc = mips_pkg::RESET_PC;
    idx = 0;
    // branches only go forward, so this ends
    while (idx < PROG_LEN) begin
        ins = prog[idx];
        a = gpr[ins.i.rs];
        b = gpr[ins.i.rt];
        sext = {{16{ins.i.imm[15]}}, ins.i.imm};
        ea = a + sext;
        nxt = pc + 32'd4;
        res = '0;
        dst = ins.i.rt;
        wr_en = 1'b0;
        case (ins.i.opcode)
            mips_pkg::OP_SPECIAL: begin
                dst = ins.r.rd;
                wr_en = 1'b1;
                case (ins.r.funct)
                    mips_pkg::FN_ADDU: res = a + b;
                    mips_pkg::FN_SUBU: res = a - b;
                    mips_pkg::FN_AND:  res = a & b;
                    mips_pkg::FN_OR:   res = a | b;
                    mips_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    // unsupported funct, zero word included
                    default: wr_en = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                res = a + sext;
                wr_en = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                res = a | {16'h0000, ins.i.imm};
                wr_en = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                res = {ins.i.imm, 16'h0000};
                wr_en = 1'b1;
            end
            mips_pkg::OP_LW: begin
                res = mem_model[ea[7:2]];
                wr_en = 1'b1;
            end
            mips_pkg::OP_SW: begin
                mem_model[ea[7:2]] = b;
                exp_st.push_back(store_rec_t'{ea, b});
            end
            // target is pc+4 plus the word offset
            mips_pkg::OP_BEQ: if (a == b) nxt = pc + 32'd4 + (sext << 2);
            mips_pkg::OP_BNE: if (a != b) nxt = pc + 32'd4 + (sext << 2);
            default: ;
        endcase
        if (wr_en && (dst != '0)) begin
            gpr[dst] = res;
            exp_wb.push_back(wb_rec_t'{pc, dst, res});
        end
        pc = nxt;
        idx = int'((pc - mips_pkg::RESET_PC) >> 2);
    end
endtask

// ==== dv/tb_mycpu.sv ====
`timescale 1ns/1ps

module tb_mycpu;

    localparam int PROG_LEN  = 64;
    localparam int DATA_LEN  = 64;
    // generous bound for the whole program with worst bus latency
    localparam int RUN_LIMIT = 20000;

    logic                 clk          = 1'b0;
    logic                 rst          = 1'b1;
    logic                 inst_req;
    mips_pkg::word_t      inst_addr;
    mips_pkg::word_t      inst_rdata   = '0;
    logic                 inst_addr_ok = 1'b0;
    logic                 inst_data_ok = 1'b0;
    logic                 data_req;
    logic                 data_wr;
    mips_pkg::word_t      data_addr;
    mips_pkg::word_t      data_wdata;
    mips_pkg::word_t      data_rdata   = '0;
    logic                 data_addr_ok = 1'b0;
    logic                 data_data_ok = 1'b0;
    mips_pkg::word_t      debug_wb_pc;
    mips_pkg::rwen_t      debug_wb_rf_wen;
    mips_pkg::creg_addr_t debug_wb_rf_wnum;
    mips_pkg::word_t      debug_wb_rf_wdata;

    int                   seed = 55136;
    // program image at RESET_PC and data region at address 0
    mips_pkg::instr_t     prog [0:PROG_LEN-1];
    mips_pkg::word_t      dmem_words [0:DATA_LEN-1];

    mycpu uut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // initial data content mixing every address bit
    function automatic mips_pkg::word_t fill_word(input mips_pkg::word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5ac3_0f96;
    endfunction

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    // words past the program read as zero
    function automatic mips_pkg::word_t fetch_word(input mips_pkg::word_t addr);
        mips_pkg::word_t off;
        off = addr - mips_pkg::RESET_PC;
        if (off < PROG_LEN * 4) begin
            return prog[off[7:2]];
        end
        return '0;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t exp,
                              input mips_pkg::word_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input mips_pkg::creg_addr_t exp,
                             input mips_pkg::creg_addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_wen(input string name, input mips_pkg::rwen_t exp,
                             input mips_pkg::rwen_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

`include "tb_mips_ref.svh"

    // responder phase is 0 when idle, 1 before addr_ok and 2 before data_ok
    int                   i_phase = 0;
    int                   i_cnt = 0;
    mips_pkg::word_t      i_hold;
    logic                 fetch_seen = 1'b0;
    int                   d_phase = 0;
    int                   d_cnt = 0;
    mips_pkg::word_t      d_hold;
    mips_pkg::word_t      d_wdata;
    logic                 d_wr;
    wb_rec_t              wb_got;
    store_rec_t           st_got;

    // random mix of alu, immediate, memory, forward branch and nop words
    task automatic build_program();
        mips_pkg::instr_t ins;
        int               kind;
        for (int k = 0; k < PROG_LEN; k++) begin
            ins = '0;
            kind = rand_below(12);
            // only a few registers so results feed each other
            ins.r.rs = mips_pkg::creg_addr_t'(rand_below(8));
            ins.r.rt = mips_pkg::creg_addr_t'(rand_below(8));
            ins.r.rd = mips_pkg::creg_addr_t'(rand_below(8));
            case (kind)
                0: ins.r.funct = mips_pkg::FN_ADDU;
                1: ins.r.funct = mips_pkg::FN_SUBU;
                2: ins.r.funct = mips_pkg::FN_AND;
                3: ins.r.funct = mips_pkg::FN_OR;
                4: ins.r.funct = mips_pkg::FN_SLT;
                5, 6, 7: begin
                    ins.i.opcode = (kind == 5) ? mips_pkg::OP_ADDIU :
                                   (kind == 6) ? mips_pkg::OP_ORI : mips_pkg::OP_LUI;
                    ins.i.imm    = 16'(rand_below(65536));
                end
                8, 9: begin
                    // base $zero with a word offset inside the data region
                    ins.i.opcode = (kind == 8) ? mips_pkg::OP_LW : mips_pkg::OP_SW;
                    ins.i.rs     = '0;
                    ins.i.imm    = 16'(rand_below(DATA_LEN) * 4);
                end
                10: begin
                    ins.i.opcode = (rand_below(2) == 0) ? mips_pkg::OP_BEQ : mips_pkg::OP_BNE;
                    ins.i.imm    = 16'(1 + rand_below(3));
                end
                default: begin
                    // all-zero word or unsupported funct (nor)
                    if (rand_below(2) == 0) begin
                        ins = '0;
                    end else begin
                        ins.r.funct = 6'h27;
                    end
                end
            endcase
            prog[k] = ins;
        end
    endtask

    // instruction channel memory
    always @(negedge clk) begin
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        if (rst) begin
            i_phase = 0;
        end else begin
            if ((i_phase == 0) && inst_req) begin
                if (!fetch_seen) begin
                    check_word("first_fetch_addr", mips_pkg::RESET_PC, inst_addr);
                end
                fetch_seen = 1'b1;
                i_hold = inst_addr;
                i_cnt = rand_below(4);
                i_phase = 1;
            end else if (i_phase == 1) begin
                if (!inst_req) begin
                    abort_run("inst_req dropped before addr_ok");
                end
                check_word("inst_addr_hold", i_hold, inst_addr);
            end else if ((i_phase == 2) && inst_req) begin
                abort_run("second inst_req before data_ok");
            end
            if ((i_phase == 1) && (i_cnt == 0)) begin
                inst_addr_ok = 1'b1;
                i_cnt = rand_below(4);
                i_phase = 2;
            end else if (i_phase == 1) begin
                i_cnt--;
            end
            // zero count right after addr_ok means same-edge data_ok
            if ((i_phase == 2) && (i_cnt == 0)) begin
                inst_data_ok = 1'b1;
                inst_rdata = fetch_word(i_hold);
                i_phase = 0;
            end else if (i_phase == 2) begin
                i_cnt--;
            end
        end
    end

    // data channel memory checking stores when the address is taken
    always @(negedge clk) begin
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        if (rst) begin
            d_phase = 0;
        end else begin
            if ((d_phase == 0) && data_req) begin
                if ((data_addr >= DATA_LEN * 4) || (data_addr[1:0] != 2'b00)) begin
                    abort_run("data access outside the data region or unaligned");
                end
                d_hold = data_addr;
                d_wdata = data_wdata;
                d_wr = data_wr;
                d_cnt = rand_below(4);
                d_phase = 1;
            end else if (d_phase == 1) begin
                if (!data_req) begin
                    abort_run("data_req dropped before addr_ok");
                end
                check_word("data_addr_hold", d_hold, data_addr);
                check_word("data_wdata_hold", d_wdata, data_wdata);
            end else if ((d_phase == 2) && data_req) begin
                abort_run("second data_req before data_ok");
            end
            if ((d_phase == 1) && (d_cnt == 0)) begin
                data_addr_ok = 1'b1;
                if (d_wr) begin
                    if (exp_st.size() == 0) begin
                        abort_run("data store with no store expected");
                    end else begin
                        st_got = exp_st.pop_front();
                        check_word("store_addr", st_got.addr, d_hold);
                        check_word("store_data", st_got.data, d_wdata);
                        dmem_words[d_hold[7:2]] = d_wdata;
                    end
                end
                d_cnt = rand_below(4);
                d_phase = 2;
            end else if (d_phase == 1) begin
                d_cnt--;
            end
            if ((d_phase == 2) && (d_cnt == 0)) begin
                data_data_ok = 1'b1;
                data_rdata = dmem_words[d_hold[7:2]];
                d_phase = 0;
            end else if (d_phase == 2) begin
                d_cnt--;
            end
        end
    end

    // writeback trace against the reference queue
    always @(negedge clk) begin
        if (!rst) begin
            // $zero never shows up as written
            if (debug_wb_rf_wnum == '0) begin
                check_wen("zero_reg_wen", '0, debug_wb_rf_wen);
            end
            if (debug_wb_rf_wen != '0) begin
                check_wen("wen_all_ones", 4'hf, debug_wb_rf_wen);
                if (exp_wb.size() == 0) begin
                    abort_run("register write with no write expected");
                end else begin
                    wb_got = exp_wb.pop_front();
                    check_word("wb_pc", wb_got.pc, debug_wb_pc);
                    check_reg("wb_wnum", wb_got.num, debug_wb_rf_wnum);
                    check_word("wb_wdata", wb_got.data, debug_wb_rf_wdata);
                end
            end
        end
    end

    initial begin
        int cyc;
        build_program();
        for (int i = 0; i < DATA_LEN; i++) begin
            dmem_words[i] = fill_word(i * 4);
        end
        run_reference();
        $display("reference: %0d register writes, %0d stores", exp_wb.size(), exp_st.size());
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (inst_req || data_req) begin
            abort_run("bus request active right after reset");
        end
        check_wen("reset_wen", '0, debug_wb_rf_wen);
        cyc = 0;
        while (!inst_req) begin
            if (cyc == 10) begin
                abort_run("DUT stalled, no fetch request after reset");
            end
            cyc++;
            @(negedge clk);
        end
        cyc = 0;
        while ((exp_wb.size() != 0) || (exp_st.size() != 0)) begin
            if (cyc == RUN_LIMIT) begin
                abort_run("DUT stalled, expected writes or stores still pending");
            end
            cyc++;
            @(negedge clk);
        end
        // trailing nops must not retire with a write
        repeat (20) @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== hw/core_mem_if.sv ====
`timescale 1ns/1ps

interface core_mem_if;

    // core side request, stable while valid and not done
    sram_bus_pkg::mem_req_t req;
    // read data, valid with done
    mips_pkg::word_t        rdata;
    // one-cycle completion pulse
    logic                   done;
    // raw bus acks, mirrored for checks on the core side
    logic                   addr_ok;
    logic                   data_ok;

    modport core (
        output req,
        input  rdata, done, addr_ok, data_ok
    );

    modport port (
        input  req,
        output rdata, done, addr_ok, data_ok
    );

endinterface

// ==== hw/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
    input  logic                 clk,
    input  logic                 rst,
    output mips_pkg::creg_addr_t rs_addr,
    output mips_pkg::creg_addr_t rt_addr,
    input  mips_pkg::word_t      rs_data,
    input  mips_pkg::word_t      rt_data,
    output logic                 rf_we,
    output mips_pkg::creg_addr_t rf_waddr,
    output mips_pkg::word_t      rf_wdata,
    output mips_pkg::word_t      wb_pc,
    output mips_pkg::rwen_t      wb_rf_wen,
    core_mem_if.core             imem,
    core_mem_if.core             dmem
);

    logic [1:0]           state;
    mips_pkg::word_t      pc;
    // instruction register, held for the whole instruction
    mips_pkg::instr_t     ir;
    // alu result or load data
    mips_pkg::word_t      res_q;
    mips_pkg::word_t      npc_q;

    mips_pkg::word_t      imm_sext;
    mips_pkg::word_t      imm_zext;
    mips_pkg::word_t      pc_plus4;
    mips_pkg::word_t      br_target;
    mips_pkg::word_t      alu_res;
    mips_pkg::creg_addr_t dest;
    logic                 writes_reg;
    logic                 is_load;
    logic                 is_store;
    logic                 taken;

    // register operands straight from the ir
    assign rs_addr = ir.r.rs;
    assign rt_addr = ir.r.rt;

    assign imm_sext  = {{16{ir.i.imm[15]}}, ir.i.imm};
    assign imm_zext  = {16'h0000, ir.i.imm};
    assign pc_plus4  = pc + 32'd4;
    // target relative to pc+4 as there is no delay slot
    assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00};

    // decode and alu
    always_comb begin
        alu_res    = '0;
        dest       = ir.i.rt;
        writes_reg = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        taken      = 1'b0;
        case (ir.i.opcode)
            mips_pkg::OP_SPECIAL: begin
                dest       = ir.r.rd;
                // nonzero shamt retires as nop
                writes_reg = (ir.r.shamt == 5'd0);
                case (ir.r.funct)
                    mips_pkg::FN_ADDU: alu_res = rs_data + rt_data;
                    mips_pkg::FN_SUBU: alu_res = rs_data - rt_data;
                    mips_pkg::FN_AND:  alu_res = rs_data & rt_data;
                    mips_pkg::FN_OR:   alu_res = rs_data | rt_data;
                    mips_pkg::FN_SLT: begin
                        alu_res = {31'd0, $signed(rs_data) < $signed(rt_data)};
                    end
                    // includes the all-zero word
                    default: writes_reg = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                alu_res    = rs_data + imm_sext;
                writes_reg = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                alu_res    = rs_data | imm_zext;
                writes_reg = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                alu_res    = {ir.i.imm, 16'h0000};
                writes_reg = 1'b1;
            end
            mips_pkg::OP_LW: begin
                // effective address
                alu_res    = rs_data + imm_sext;
                writes_reg = 1'b1;
                is_load    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                alu_res  = rs_data + imm_sext;
                is_store = 1'b1;
            end
            mips_pkg::OP_BEQ: taken = (rs_data == rt_data);
            mips_pkg::OP_BNE: taken = (rs_data != rt_data);
            default: ;
        endcase
    end

    // control sequence fetch, exec, mem, wb
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mips_pkg::ST_FETCH;
            pc    <= mips_pkg::RESET_PC;
        end else begin
            case (state)
                mips_pkg::ST_FETCH: begin
                    if (imem.done) begin
                        state <= mips_pkg::ST_EXEC;
                    end
                end
                mips_pkg::ST_EXEC: begin
                    state <= (is_load || is_store) ? mips_pkg::ST_MEM : mips_pkg::ST_WB;
                end
                mips_pkg::ST_MEM: begin
                    if (dmem.done) begin
                        state <= mips_pkg::ST_WB;
                    end
                end
                default: begin
                    // retire
                    state <= mips_pkg::ST_FETCH;
                    pc    <= npc_q;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if ((state == mips_pkg::ST_FETCH) && imem.done) begin
            ir <= imem.rdata;
        end
        if (state == mips_pkg::ST_EXEC) begin
            res_q <= alu_res;
            npc_q <= taken ? br_target : pc_plus4;
        end
        if ((state == mips_pkg::ST_MEM) && dmem.done && is_load) begin
            res_q <= dmem.rdata;
        end
    end

    // read-only instruction channel
    always_comb begin
        imem.req.valid = (state == mips_pkg::ST_FETCH);
        imem.req.wr    = 1'b0;
        imem.req.addr  = pc;
        imem.req.wdata = '0;
    end

    // data channel with word accesses only
    always_comb begin
        dmem.req.valid = (state == mips_pkg::ST_MEM);
        dmem.req.wr    = is_store;
        dmem.req.addr  = res_q;
        dmem.req.wdata = rt_data;
    end

    // writeback and trace
    assign rf_we     = (state == mips_pkg::ST_WB) && writes_reg;
    assign rf_waddr  = dest;
    assign rf_wdata  = res_q;
    assign wb_pc     = pc;
    assign wb_rf_wen = {4{rf_we && (dest != '0)}};

    // bus acks only show up on the channel the core is using
    a_iack_owner: assert property (@(posedge clk) disable iff (rst)
        (imem.addr_ok || imem.data_ok) |-> imem.req.valid);

    a_dack_owner: assert property (@(posedge clk) disable iff (rst)
        (dmem.addr_ok || dmem.data_ok) |-> dmem.req.valid);

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

    // basic datapath widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    // debug writeback byte enable, all bits equal
    typedef logic [3:0]  rwen_t;

    // one instruction word, read as R or I format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            creg_addr_t rs;
            creg_addr_t rt;
            creg_addr_t rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            creg_addr_t  rs;
            creg_addr_t  rt;
            logic [15:0] imm;
        } i;
    } instr_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL function codes
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // boot vector, kseg1 rom
    localparam word_t RESET_PC = 32'hbfc0_0000;

    // multicycle core control states
    localparam logic [1:0] ST_FETCH = 2'd0;
    localparam logic [1:0] ST_EXEC  = 2'd1;
    localparam logic [1:0] ST_MEM   = 2'd2;
    localparam logic [1:0] ST_WB    = 2'd3;

endpackage

// ==== hw/mycpu.sv ====
`timescale 1ns/1ps

module mycpu (
    input  logic                 clk,
    input  logic                 rst,

    // instruction channel
    output logic                 inst_req,
    output mips_pkg::word_t      inst_addr,
    input  mips_pkg::word_t      inst_rdata,
    input  logic                 inst_addr_ok,
    input  logic                 inst_data_ok,

    // data channel
    output logic                 data_req,
    output logic                 data_wr,
    output mips_pkg::word_t      data_addr,
    output mips_pkg::word_t      data_wdata,
    input  mips_pkg::word_t      data_rdata,
    input  logic                 data_addr_ok,
    input  logic                 data_data_ok,

    // writeback trace
    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);

    core_mem_if imem_if();
    core_mem_if dmem_if();

    mips_pkg::creg_addr_t rs_addr;
    mips_pkg::creg_addr_t rt_addr;
    mips_pkg::word_t      rs_data;
    mips_pkg::word_t      rt_data;
    logic                 rf_we;

    // register write port shares the trace nets
    mips_core core (
        .clk, .rst,
        .rs_addr, .rt_addr, .rs_data, .rt_data,
        .rf_we, .rf_waddr(debug_wb_rf_wnum), .rf_wdata(debug_wb_rf_wdata),
        .wb_pc(debug_wb_pc), .wb_rf_wen(debug_wb_rf_wen),
        .imem(imem_if.core), .dmem(dmem_if.core)
    );

    reg_file rf (
        .clk, .rst,
        .raddr1(rs_addr), .raddr2(rt_addr), .rdata1(rs_data), .rdata2(rt_data),
        .we(rf_we), .waddr(debug_wb_rf_wnum), .wdata(debug_wb_rf_wdata)
    );

    // fetch never writes, wr and wdata unused
    sram_handshake i_handshake (
        .clk, .rst,
        .req(inst_req), .wr(), .addr(inst_addr), .wdata(),
        .rdata(inst_rdata), .addr_ok(inst_addr_ok), .data_ok(inst_data_ok),
        .mem(imem_if.port)
    );

    sram_handshake d_handshake (
        .clk, .rst,
        .req(data_req), .wr(data_wr), .addr(data_addr), .wdata(data_wdata),
        .rdata(data_rdata), .addr_ok(data_addr_ok), .data_ok(data_data_ok),
        .mem(dmem_if.port)
    );

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 rst,
    input  mips_pkg::creg_addr_t raddr1,
    input  mips_pkg::creg_addr_t raddr2,
    output mips_pkg::word_t      rdata1,
    output mips_pkg::word_t      rdata2,
    input  logic                 we,
    input  mips_pkg::creg_addr_t waddr,
    input  mips_pkg::word_t      wdata
);

    // entry 0 cleared on reset and never written
    mips_pkg::word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// ==== hw/sram_bus_pkg.sv ====
package sram_bus_pkg;

    // phase of one access on an SRAM-like channel
    typedef enum logic [1:0] {
        // nothing outstanding
        HS_IDLE,
        // req high, waiting for addr_ok
        HS_ADDR,
        // address taken, waiting for data_ok
        HS_DATA
    } hs_state_e;

    // request as the core sees it, held until done
    typedef struct packed {
        logic            valid;
        // write when set, read otherwise
        logic            wr;
        mips_pkg::word_t addr;
        // only meaningful for writes
        mips_pkg::word_t wdata;
    } mem_req_t;

endpackage

// ==== hw/sram_handshake.sv ====
`timescale 1ns/1ps

module sram_handshake (
    input  logic            clk,
    input  logic            rst,
    output logic            req,
    output logic            wr,
    output mips_pkg::word_t addr,
    output mips_pkg::word_t wdata,
    input  mips_pkg::word_t rdata,
    input  logic            addr_ok,
    input  logic            data_ok,
    core_mem_if.port        mem
);

    sram_bus_pkg::hs_state_e state;

    // phase tracking, one access in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sram_bus_pkg::HS_IDLE;
        end else begin
            case (state)
                sram_bus_pkg::HS_IDLE: begin
                    if (mem.req.valid) begin
                        state <= sram_bus_pkg::HS_ADDR;
                    end
                end
                sram_bus_pkg::HS_ADDR: begin
                    // zero-wait memory can ack both on one edge
                    if (addr_ok) begin
                        state <= data_ok ? sram_bus_pkg::HS_IDLE : sram_bus_pkg::HS_DATA;
                    end
                end
                sram_bus_pkg::HS_DATA: begin
                    if (data_ok) begin
                        state <= sram_bus_pkg::HS_IDLE;
                    end
                end
                default: state <= sram_bus_pkg::HS_IDLE;
            endcase
        end
    end

    // req only during address phase, drops after addr_ok
    assign req   = (state == sram_bus_pkg::HS_ADDR);
    // core holds these stable, so drive straight through
    assign wr    = mem.req.wr;
    assign addr  = mem.req.addr;
    assign wdata = mem.req.wdata;

    // completion on the data_ok edge
    assign mem.done = ((state == sram_bus_pkg::HS_ADDR) && addr_ok && data_ok)
                   || ((state == sram_bus_pkg::HS_DATA) && data_ok);
    assign mem.rdata   = rdata;
    assign mem.addr_ok = addr_ok;
    assign mem.data_ok = data_ok;

    // address and write data held until the bus takes them
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        req && !addr_ok |=> $stable(addr) && $stable(wdata) && $stable(wr));

    // no response when nothing is outstanding
    a_no_idle_data: assert property (@(posedge clk) disable iff (rst)
        (state == sram_bus_pkg::HS_IDLE) |-> !data_ok);

    // core request frozen while an access is busy
    a_req_frozen: assert property (@(posedge clk) disable iff (rst)
        (state != sram_bus_pkg::HS_IDLE) && !mem.done |=> $stable(mem.req));

endmodule

// ==== mycpu.f ====
+incdir+dv
hw/mips_pkg.sv
hw/sram_bus_pkg.sv
hw/core_mem_if.sv
hw/sram_handshake.sv
hw/reg_file.sv
hw/mips_core.sv
hw/mycpu.sv
dv/tb_mycpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mycpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mycpu -f mycpu.f -o tb_mycpu

# a failing run still prints its output before the check below
output=$(./obj_dir/tb_mycpu 2>&1 || true)
echo "$output"
echo "$output" | grep -q -x -F "=== PASS ==="
